// File: diskPkg.sv
// Disk to SD mapping package
// Address widths, drive geometry table, credit counts and FSM encodings
// shared by the mapping path blocks

package diskPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Address fields
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [9:0]  cylT;
   typedef logic [4:0]  trackT;
   typedef logic [4:0]  sectT;
   typedef logic [31:0] sdAddrT;
   typedef logic [1:0]  driveTypeT;

   ////////////////////////////////////////////////////////////////////////////
   // Drive geometry, indexed by drive type
   ////////////////////////////////////////////////////////////////////////////

   localparam int NUM_DRIVE_TYPES = 4;

   // Surfaces per cylinder
   localparam trackT GEOM_SURF [NUM_DRIVE_TYPES] = '{5'd19, 5'd19, 5'd5, 5'd2};
   // Sectors per track
   localparam sectT  GEOM_SECT [NUM_DRIVE_TYPES] = '{5'd20, 5'd20, 5'd22, 5'd4};
   // Cylinders per pack, type 3 is the small test pack
   localparam cylT   GEOM_CYL  [NUM_DRIVE_TYPES] = '{10'd411, 10'd815, 10'd815, 10'd8};

   // Host side queue, one credit per entry
   localparam int QUEUE_DEPTH = 4;
   localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
   // Pointer carries one wrap bit
   typedef logic [QPTR_W:0] qPtrT;

   // SD side credits
   localparam int SD_CREDITS = 2;
   localparam int SD_CRED_W  = $clog2(SD_CREDITS + 1);
   typedef logic [SD_CRED_W-1:0] sdCredT;
   localparam sdCredT SD_CRED_MAX = sdCredT'(SD_CREDITS);

   // Calculator FSM
   typedef enum logic [1:0] {CALC_IDLE, CALC_TRACK, CALC_SECT, CALC_WORD} calcStateT;

   // Request generator FSM
   typedef enum logic [1:0] {GEN_IDLE, GEN_FIRST, GEN_SECOND} genStateT;

endpackage

// File: chsCmdIf.sv
// CHS command interface
// Carries a checked cylinder/track/sector request plus its geometry
// counts from the queue to the address calculator, credit going back

`timescale 1ns/100ps

interface chsCmdIf;

   // Request strobe, one cycle
   logic               valid;
   // Disk address
   diskPkg::cylT       cyl;
   diskPkg::trackT     track;
   diskPkg::sectT      sect;
   // Geometry of the addressed drive
   diskPkg::trackT     surfCnt;
   diskPkg::sectT      sectCnt;
   // Address lies outside the pack
   logic               rangeErr;
   // Credit return, one cycle
   logic               credit;

   modport src
   (
      output valid, cyl, track, sect, surfCnt, sectCnt, rangeErr,
      input  credit
   );

   modport dst
   (
      input  valid, cyl, track, sect, surfCnt, sectCnt, rangeErr,
      output credit
   );

endinterface

// File: sdReqIf.sv
// SD request interface
// Carries a computed SD sector address, or an error marker, from the
// calculator to the request generator with a credit return

`timescale 1ns/100ps

interface sdReqIf;

   // Result strobe
   logic             valid;
   // First SD sector of the disk sector
   diskPkg::sdAddrT  addr;
   // Range error, addr is zero
   logic             err;
   // Credit return
   logic             credit;

   modport src
   (
      output valid, addr, err,
      input  credit
   );

   modport dst
   (
      input  valid, addr, err,
      output credit
   );

endinterface

// File: geometryTable.sv
// Drive geometry lookup
// Maps a drive type to its surface, sector and cylinder counts through a
// one-hot select over the package tables

`timescale 1ns/100ps

module geometryTable
(
   input  diskPkg::driveTypeT driveType,
   output diskPkg::trackT     surfCnt,
   output diskPkg::sectT      sectCnt,
   output diskPkg::cylT       cylCnt
);

   // One select line per drive type
   logic [diskPkg::NUM_DRIVE_TYPES-1:0] sel;

   always_comb
   begin
      sel     = '0;
      surfCnt = '0;
      sectCnt = '0;
      cylCnt  = '0;
      // Decode 1-of-4
      for (int i = 0; i < diskPkg::NUM_DRIVE_TYPES; i++)
      begin
         sel[i] = (driveType == diskPkg::driveTypeT'(i));
      end
      // OR together the selected row
      for (int i = 0; i < diskPkg::NUM_DRIVE_TYPES; i++)
      begin
         if (sel[i])
         begin
            surfCnt = surfCnt | diskPkg::GEOM_SURF[i];
            sectCnt = sectCnt | diskPkg::GEOM_SECT[i];
            cylCnt  = cylCnt  | diskPkg::GEOM_CYL[i];
         end
      end
   end

endmodule

// File: chsCmdQueue.sv
// CHS command queue
// Buffers host disk requests, returns host credits as entries leave,
// and tags the head entry with its geometry and a range check

`timescale 1ns/100ps

module chsCmdQueue
(
   input  logic               clk,
   input  logic               rst,
   input  logic               cmdValid,
   input  diskPkg::driveTypeT cmdDrive,
   input  diskPkg::cylT       cmdCyl,
   input  diskPkg::trackT     cmdTrack,
   input  diskPkg::sectT      cmdSect,
   output logic               cmdCredit,
   chsCmdIf.src               cmdBus
);

   // FIFO storage
   diskPkg::driveTypeT fifoDrive [diskPkg::QUEUE_DEPTH];
   diskPkg::cylT       fifoCyl   [diskPkg::QUEUE_DEPTH];
   diskPkg::trackT     fifoTrack [diskPkg::QUEUE_DEPTH];
   diskPkg::sectT      fifoSect  [diskPkg::QUEUE_DEPTH];

   diskPkg::qPtrT      wrPtr;
   diskPkg::qPtrT      rdPtr;
   logic               fifoEmpty;
   logic               pop;
   // Single credit toward the calculator
   logic               calcCredit;

   // Head entry
   diskPkg::driveTypeT headDrive;
   diskPkg::cylT       headCyl;
   diskPkg::trackT     headTrack;
   diskPkg::sectT      headSect;

   // Geometry of head entry
   diskPkg::trackT     surfCnt;
   diskPkg::sectT      sectCnt;
   diskPkg::cylT       cylCnt;

   ////////////////////////////////////////////////////////////////////////////
   // FIFO
   ////////////////////////////////////////////////////////////////////////////

   // Host credits keep the FIFO from overflowing
   always_ff @(posedge clk)
   begin
      if (cmdValid)
      begin
         fifoDrive[wrPtr[diskPkg::QPTR_W-1:0]] <= cmdDrive;
         fifoCyl[wrPtr[diskPkg::QPTR_W-1:0]]   <= cmdCyl;
         fifoTrack[wrPtr[diskPkg::QPTR_W-1:0]] <= cmdTrack;
         fifoSect[wrPtr[diskPkg::QPTR_W-1:0]]  <= cmdSect;
      end
   end

   assign fifoEmpty = (wrPtr == rdPtr);
   // Leave only when the calculator can take it
   assign pop       = !fifoEmpty && calcCredit;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr      <= '0;
         rdPtr      <= '0;
         calcCredit <= 1'b1;
      end
      else
      begin
         if (cmdValid)
            wrPtr <= wrPtr + diskPkg::qPtrT'(1);
         if (pop)
            rdPtr <= rdPtr + diskPkg::qPtrT'(1);
         // Spend on pop, refill on credit return
         case ({pop, cmdBus.credit})
            2'b10:   calcCredit <= 1'b0;
            2'b01:   calcCredit <= 1'b1;
            default: calcCredit <= calcCredit;
         endcase
      end
   end

   assign headDrive = fifoDrive[rdPtr[diskPkg::QPTR_W-1:0]];
   assign headCyl   = fifoCyl[rdPtr[diskPkg::QPTR_W-1:0]];
   assign headTrack = fifoTrack[rdPtr[diskPkg::QPTR_W-1:0]];
   assign headSect  = fifoSect[rdPtr[diskPkg::QPTR_W-1:0]];

   ////////////////////////////////////////////////////////////////////////////
   // Geometry and range check
   ////////////////////////////////////////////////////////////////////////////

   geometryTable geometryTable_inst
   (
      .driveType (headDrive),
      .surfCnt   (surfCnt),
      .sectCnt   (sectCnt),
      .cylCnt    (cylCnt)
   );

   assign cmdBus.valid    = pop;
   assign cmdBus.cyl      = headCyl;
   assign cmdBus.track    = headTrack;
   assign cmdBus.sect     = headSect;
   assign cmdBus.surfCnt  = surfCnt;
   assign cmdBus.sectCnt  = sectCnt;
   // Any field at or past its count is off the pack
   assign cmdBus.rangeErr = (headCyl >= cylCnt) || (headTrack >= surfCnt) ||
                            (headSect >= sectCnt);

   // Host credit back as the entry leaves
   assign cmdCredit = pop;

endmodule

// File: sectorAddrCalc.sv
// SD sector address calculator
// Converts a CHS request to an SD sector address by repeated addition,
// ((cyl * surf + track) * sect + sector) * 2, with no multiplier

`timescale 1ns/100ps

module sectorAddrCalc
(
   input  logic  clk,
   input  logic  rst,
   chsCmdIf.dst  cmdBus,
   sdReqIf.src   reqBus
);

   diskPkg::calcStateT state;
   // Range error pending for this request
   logic               errFlag;
   // Single credit toward the generator
   logic               genCredit;
   logic               creditPulse;
   logic               resultOut;

   // Datapath
   diskPkg::sdAddrT    sum;
   diskPkg::sdAddrT    temp;
   logic [4:0]         loop;
   diskPkg::trackT     trackReg;
   diskPkg::sectT      sectReg;
   diskPkg::sectT      sectCntReg;

   // Result leaves from the word state once a credit is held
   assign resultOut = (state == diskPkg::CALC_WORD) && genCredit;

   ////////////////////////////////////////////////////////////////////////////
   // Control
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state       <= diskPkg::CALC_IDLE;
         errFlag     <= 1'b0;
         genCredit   <= 1'b1;
         creditPulse <= 1'b0;
      end
      else
      begin
         // Credit back once idle again
         creditPulse <= resultOut;
         case ({resultOut, reqBus.credit})
            2'b10:   genCredit <= 1'b0;
            2'b01:   genCredit <= 1'b1;
            default: genCredit <= genCredit;
         endcase
         case (state)
            diskPkg::CALC_IDLE:
            begin
               if (cmdBus.valid)
               begin
                  errFlag <= cmdBus.rangeErr;
                  // Errors skip the arithmetic
                  state   <= cmdBus.rangeErr ? diskPkg::CALC_WORD : diskPkg::CALC_TRACK;
               end
            end
            diskPkg::CALC_TRACK:
            begin
               if (loop == 5'd0)
                  state <= diskPkg::CALC_SECT;
            end
            diskPkg::CALC_SECT:
            begin
               if (loop == 5'd0)
                  state <= diskPkg::CALC_WORD;
            end
            default:
            begin
               // Wait here for a generator credit
               if (genCredit)
                  state <= diskPkg::CALC_IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Arithmetic
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      case (state)
         diskPkg::CALC_IDLE:
         begin
            if (cmdBus.valid)
            begin
               sum        <= '0;
               temp       <= diskPkg::sdAddrT'(cmdBus.cyl);
               loop       <= cmdBus.surfCnt;
               trackReg   <= cmdBus.track;
               sectReg    <= cmdBus.sect;
               sectCntReg <= cmdBus.sectCnt;
            end
         end
         diskPkg::CALC_TRACK:
         begin
            // cyl * surf done, add track
            if (loop == 5'd0)
            begin
               sum  <= '0;
               temp <= sum + diskPkg::sdAddrT'(trackReg);
               loop <= sectCntReg;
            end
            else
            begin
               sum  <= sum + temp;
               loop <= loop - 5'd1;
            end
         end
         diskPkg::CALC_SECT:
         begin
            // Partial * sect done, add sector
            if (loop == 5'd0)
            begin
               sum <= sum + diskPkg::sdAddrT'(sectReg);
            end
            else
            begin
               sum  <= sum + temp;
               loop <= loop - 5'd1;
            end
         end
         default:
         begin
            sum <= sum;
         end
      endcase
   end

   // Two SD sectors per disk sector
   assign reqBus.valid  = resultOut;
   assign reqBus.addr   = errFlag ? '0 : sum + sum;
   assign reqBus.err    = errFlag;
   assign cmdBus.credit = creditPulse;

endmodule

// File: sdRequestGen.sv
// SD block request generator
// Issues two SD block requests per disk sector address, or one error
// pulse, paced by credits from the SD side

`timescale 1ns/100ps

module sdRequestGen
(
   input  logic            clk,
   input  logic            rst,
   sdReqIf.dst             reqBus,
   input  logic            sdCredit,
   output logic            sdReqValid,
   output diskPkg::sdAddrT sdReqAddr,
   output logic            errValid
);

   diskPkg::genStateT state;
   diskPkg::sdCredT   sdCred;
   logic              haveCred;
   logic              issueFirst;
   logic              issueSecond;
   logic              spend;
   logic              creditPulse;

   // Latched request
   diskPkg::sdAddrT   addrReg;
   logic              errReg;

   assign haveCred    = (sdCred != '0);
   assign issueFirst  = (state == diskPkg::GEN_FIRST) && !errReg && haveCred;
   assign issueSecond = (state == diskPkg::GEN_SECOND) && haveCred;
   assign spend       = issueFirst || issueSecond;

   assign sdReqValid = spend;
   // Second block is the next SD sector
   assign sdReqAddr  = (state == diskPkg::GEN_SECOND) ? addrReg + diskPkg::sdAddrT'(1) : addrReg;
   assign errValid   = (state == diskPkg::GEN_FIRST) && errReg;

   assign reqBus.credit = creditPulse;

   always_ff @(posedge clk)
   begin
      if ((state == diskPkg::GEN_IDLE) && reqBus.valid)
      begin
         addrReg <= reqBus.addr;
         errReg  <= reqBus.err;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // FSM and SD credit counter
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state       <= diskPkg::GEN_IDLE;
         sdCred      <= diskPkg::SD_CRED_MAX;
         creditPulse <= 1'b0;
      end
      else
      begin
         // Done after the second block or the error
         creditPulse <= issueSecond || errValid;
         // Up/down, saturating at the reset count
         case ({sdCredit, spend})
            2'b10:
            begin
               if (sdCred != diskPkg::SD_CRED_MAX)
                  sdCred <= sdCred + diskPkg::sdCredT'(1);
            end
            2'b01:   sdCred <= sdCred - diskPkg::sdCredT'(1);
            default: sdCred <= sdCred;
         endcase
         case (state)
            diskPkg::GEN_IDLE:
            begin
               if (reqBus.valid)
                  state <= diskPkg::GEN_FIRST;
            end
            diskPkg::GEN_FIRST:
            begin
               if (errReg)
                  state <= diskPkg::GEN_IDLE;
               else if (haveCred)
                  state <= diskPkg::GEN_SECOND;
            end
            default:
            begin
               // Stall here with no credit
               if (haveCred)
                  state <= diskPkg::GEN_IDLE;
            end
         endcase
      end
   end

endmodule

// File: diskSdMapper.sv
// Disk to SD mapper top level
// Queue, address calculator and SD request generator joined by
// credit-based interfaces, plain ports toward host and SD side

`timescale 1ns/100ps

module diskSdMapper
(
   input  logic               clk,
   input  logic               rst,
   // Host requests
   input  logic               cmdValid,
   input  diskPkg::driveTypeT cmdDrive,
   input  diskPkg::cylT       cmdCyl,
   input  diskPkg::trackT     cmdTrack,
   input  diskPkg::sectT      cmdSect,
   output logic               cmdCredit,
   // SD side
   input  logic               sdCredit,
   output logic               sdReqValid,
   output diskPkg::sdAddrT    sdReqAddr,
   output logic               errValid
);

   chsCmdIf cmdBus ();
   sdReqIf  reqBus ();

   chsCmdQueue chsCmdQueue_inst
   (
      .clk       (clk),
      .rst       (rst),
      .cmdValid  (cmdValid),
      .cmdDrive  (cmdDrive),
      .cmdCyl    (cmdCyl),
      .cmdTrack  (cmdTrack),
      .cmdSect   (cmdSect),
      .cmdCredit (cmdCredit),
      .cmdBus    (cmdBus.src)
   );

   sectorAddrCalc sectorAddrCalc_inst
   (
      .clk    (clk),
      .rst    (rst),
      .cmdBus (cmdBus.dst),
      .reqBus (reqBus.src)
   );

   sdRequestGen sdRequestGen_inst
   (
      .clk        (clk),
      .rst        (rst),
      .reqBus     (reqBus.dst),
      .sdCredit   (sdCredit),
      .sdReqValid (sdReqValid),
      .sdReqAddr  (sdReqAddr),
      .errValid   (errValid)
   );

endmodule

// File: tbDiskSdMapper.sv
// Disk to SD mapper testbench
// Runs a table of CHS requests through the mapper under host credits,
// returns SD credits after random stalls and checks every block address

`timescale 1ns/100ps

module tbDiskSdMapper;

   localparam int NUM_ROWS      = 18;
   localparam int HOST_TIMEOUT  = 4000;
   localparam int DRAIN_TIMEOUT = 8000;

   // One request per row
   // Gap is the number of idle cycles before sending
   typedef struct packed
   {
      logic [3:0]         gap;
      diskPkg::driveTypeT drive;
      diskPkg::cylT       cyl;
      diskPkg::trackT     track;
      diskPkg::sectT      sect;
      logic               expErr;
   } reqRowT;

   typedef struct packed
   {
      logic            err;
      diskPkg::sdAddrT addr;
   } expT;

   localparam reqRowT REQ_TABLE [NUM_ROWS] = '{
      '{4'd2, 2'd3, 10'd0,   5'd0,  5'd0,  1'b0},
      '{4'd4, 2'd0, 10'd410, 5'd18, 5'd19, 1'b0},
      '{4'd1, 2'd1, 10'd814, 5'd18, 5'd19, 1'b0},
      '{4'd0, 2'd2, 10'd814, 5'd4,  5'd21, 1'b0},
      '{4'd3, 2'd3, 10'd7,   5'd1,  5'd3,  1'b0},
      // Cylinder, track and sector each at its count
      '{4'd5, 2'd3, 10'd8,   5'd0,  5'd0,  1'b1},
      '{4'd0, 2'd0, 10'd0,   5'd19, 5'd0,  1'b1},
      '{4'd2, 2'd2, 10'd0,   5'd0,  5'd22, 1'b1},
      '{4'd1, 2'd3, 10'd2,   5'd1,  5'd2,  1'b0},
      // Long calculation followed by a back-to-back burst
      '{4'd6, 2'd1, 10'd300, 5'd12, 5'd9,  1'b0},
      '{4'd0, 2'd0, 10'd1,   5'd2,  5'd3,  1'b0},
      '{4'd0, 2'd2, 10'd500, 5'd3,  5'd10, 1'b0},
      '{4'd0, 2'd3, 10'd5,   5'd0,  5'd1,  1'b0},
      '{4'd0, 2'd1, 10'd100, 5'd5,  5'd7,  1'b0},
      '{4'd3, 2'd1, 10'd815, 5'd0,  5'd0,  1'b1},
      '{4'd0, 2'd0, 10'd200, 5'd10, 5'd15, 1'b0},
      '{4'd2, 2'd2, 10'd1,   5'd1,  5'd1,  1'b0},
      '{4'd0, 2'd3, 10'd7,   5'd1,  5'd3,  1'b0}
   };

   logic               clk = 1'b0;
   logic               rst;
   logic               cmdValid;
   diskPkg::driveTypeT cmdDrive;
   diskPkg::cylT       cmdCyl;
   diskPkg::trackT     cmdTrack;
   diskPkg::sectT      cmdSect;
   logic               cmdCredit;
   logic               sdCredit = 1'b0;
   logic               sdReqValid;
   diskPkg::sdAddrT    sdReqAddr;
   logic               errValid;

   // Scoreboard
   expT                expQ [$];
   int                 rdIdx       = 0;
   int                 sentCnt     = 0;
   int                 creditCnt   = 0;
   int                 maxOut      = 0;
   int                 mismatchCnt = 0;
   int                 protoCnt    = 0;
   int                 blockCnt    = 0;
   int                 errRptCnt   = 0;
   // SD side credit model
   int                 dutSdCred   = diskPkg::SD_CREDITS;
   int                 issuedCnt   = 0;
   int                 returnedCnt = 0;
   int                 gapCnt      = 0;
   logic [15:0]        lfsrState   = 16'd34547;

   diskSdMapper diskSdMapper_inst
   (
      .clk        (clk),
      .rst        (rst),
      .cmdValid   (cmdValid),
      .cmdDrive   (cmdDrive),
      .cmdCyl     (cmdCyl),
      .cmdTrack   (cmdTrack),
      .cmdSect    (cmdSect),
      .cmdCredit  (cmdCredit),
      .sdCredit   (sdCredit),
      .sdReqValid (sdReqValid),
      .sdReqAddr  (sdReqAddr),
      .errValid   (errValid)
   );

   initial
   begin
      forever #10 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////////

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit
   task automatic takeBits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsrState = lfsrNext(lfsrState);
         val       = (val << 1) | int'(lfsrState[0]);
      end
   endtask

   // ((cyl * surf + track) * sect + sector) * 2
   function automatic diskPkg::sdAddrT expectedAddr(input reqRowT row);
      int surf;
      int sect;
      int lin;
      surf = int'(diskPkg::GEOM_SURF[row.drive]);
      sect = int'(diskPkg::GEOM_SECT[row.drive]);
      lin  = ((int'(row.cyl) * surf + int'(row.track)) * sect + int'(row.sect)) * 2;
      return diskPkg::sdAddrT'(lin);
   endfunction

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
         mismatchCnt++;
      end
   endtask

   task automatic waitHostCredit(output bit timedOut);
      int cycles;
      cycles   = 0;
      timedOut = 1'b0;
      while (((sentCnt - creditCnt) >= diskPkg::QUEUE_DEPTH) && !timedOut)
      begin
         @(posedge clk);
         cycles++;
         if (cycles >= HOST_TIMEOUT)
         begin
            $display("Timeout: no host credit came back within %0d cycles", HOST_TIMEOUT);
            timedOut = 1'b1;
         end
      end
   endtask

   // All results seen and all host credits home
   task automatic waitDrain(output bit timedOut);
      int cycles;
      cycles   = 0;
      timedOut = 1'b0;
      while (((rdIdx < expQ.size()) || (sentCnt != creditCnt)) && !timedOut)
      begin
         @(posedge clk);
         cycles++;
         if (cycles >= DRAIN_TIMEOUT)
         begin
            $display("Timeout: %0d of %0d results still missing after %0d cycles",
                     expQ.size() - rdIdx, expQ.size(), DRAIN_TIMEOUT);
            timedOut = 1'b1;
         end
      end
   endtask

   task automatic finishRun(input bit timedOut);
      bit passed;
      passed = !timedOut && (mismatchCnt == 0) && (protoCnt == 0) &&
               (maxOut == diskPkg::QUEUE_DEPTH) && (rdIdx == expQ.size());
      if (maxOut != diskPkg::QUEUE_DEPTH)
         $display("Host burst reached only %0d outstanding requests", maxOut);
      $display("%0d requests, %0d blocks, %0d errValid, %0d mismatches, %0d protocol errors",
               sentCnt, blockCnt, errRptCnt, mismatchCnt, protoCnt);
      if (passed)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   endtask

   //////////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////////

   initial
   begin
      expT             entry;
      diskPkg::sdAddrT base;
      bit              timedOut;
      rst      = 1'b1;
      cmdValid = 1'b0;
      cmdDrive = '0;
      cmdCyl   = '0;
      cmdTrack = '0;
      cmdSect  = '0;
      timedOut = 1'b0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      for (int r = 0; (r < NUM_ROWS) && !timedOut; r++)
      begin
         cmdValid <= 1'b0;
         repeat (REQ_TABLE[r].gap) @(posedge clk);
         waitHostCredit(timedOut);
         if (!timedOut)
         begin
            base = expectedAddr(REQ_TABLE[r]);
            // An error gives one report where a good request gives two blocks
            if (REQ_TABLE[r].expErr)
            begin
               entry.err  = 1'b1;
               entry.addr = '0;
               expQ.push_back(entry);
            end
            else
            begin
               entry.err  = 1'b0;
               entry.addr = base;
               expQ.push_back(entry);
               entry.addr = base + diskPkg::sdAddrT'(1);
               expQ.push_back(entry);
            end
            cmdValid <= 1'b1;
            cmdDrive <= REQ_TABLE[r].drive;
            cmdCyl   <= REQ_TABLE[r].cyl;
            cmdTrack <= REQ_TABLE[r].track;
            cmdSect  <= REQ_TABLE[r].sect;
            sentCnt++;
            @(posedge clk);
         end
      end
      cmdValid <= 1'b0;
      if (!timedOut)
         waitDrain(timedOut);
      finishRun(timedOut);
   end

   //////////////////////////////////////////////////////////////////////////
   // SD credit return with random stalls
   //////////////////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin
      int pick;
      int span;
      if (rst)
      begin
         sdCredit    <= 1'b0;
         gapCnt      = 0;
         returnedCnt = 0;
      end
      else
      begin
         sdCredit <= 1'b0;
         if (gapCnt != 0)
            gapCnt = gapCnt - 1;
         else if (issuedCnt != returnedCnt)
         begin
            sdCredit    <= 1'b1;
            returnedCnt = returnedCnt + 1;
            // One in four is a long stall
            takeBits(2, pick);
            if (pick == 0)
            begin
               takeBits(6, span);
               gapCnt = span + 16;
            end
            else
            begin
               takeBits(2, span);
               gapCnt = span;
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////////
   // Monitor sampled mid-cycle
   //////////////////////////////////////////////////////////////////////////

   always @(negedge clk)
   begin
      int outstanding;
      if (rst)
      begin
         checkValue("cmdCredit", 32'(cmdCredit), 32'd0);
         checkValue("sdReqValid", 32'(sdReqValid), 32'd0);
         checkValue("errValid", 32'(errValid), 32'd0);
      end
      else
      begin
         outstanding = sentCnt - creditCnt;
         if (outstanding > maxOut)
            maxOut = outstanding;
         if (cmdCredit)
         begin
            if (outstanding == 0)
            begin
               $display("cmdCredit pulsed with no request outstanding at %0t", $time);
               protoCnt++;
            end
            else
               creditCnt++;
         end
         if (sdReqValid)
         begin
            if (dutSdCred == 0)
            begin
               $display("sdReqValid issued while the SD side held no credit at %0t", $time);
               protoCnt++;
            end
            else
               dutSdCred--;
            issuedCnt++;
            blockCnt++;
            if (rdIdx >= expQ.size())
            begin
               $display("SD block request with no result expected at %0t", $time);
               protoCnt++;
            end
            else
            begin
               checkValue("errValid", 32'(errValid), 32'(expQ[rdIdx].err));
               if (!expQ[rdIdx].err)
                  checkValue("sdReqAddr", sdReqAddr, expQ[rdIdx].addr);
               rdIdx++;
            end
         end
         if (errValid)
         begin
            errRptCnt++;
            if (rdIdx >= expQ.size())
            begin
               $display("Error report with no result expected at %0t", $time);
               protoCnt++;
            end
            else
            begin
               checkValue("errValid", 32'(errValid), 32'(expQ[rdIdx].err));
               rdIdx++;
            end
         end
         // Seen by the DUT on the next edge
         if (sdCredit)
            dutSdCred++;
      end
   end

endmodule

// File: diskSdMapper.f
diskPkg.sv
chsCmdIf.sv
sdReqIf.sv
geometryTable.sv
chsCmdQueue.sv
sectorAddrCalc.sv
sdRequestGen.sv
diskSdMapper.sv
tbDiskSdMapper.sv

// File: Makefile
# Verilator lint, build and run for the disk to SD mapper

VERILATOR ?= verilator
TOP       ?= tbDiskSdMapper
RTL_TOP   ?= diskSdMapper
FILELIST  ?= diskSdMapper.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
